// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // Datapath and memory sizing
    localparam int XLEN       = 32;
    localparam int REGS       = 32;
    localparam int REG_AW     = $clog2(REGS);
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);   // 8
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);   // 6

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        SYSTEM = 7'b1110011
    } opcodeT;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        SRA,
        PASSB                       // Forward operand b, used by lui
    } aluOpT;

    // Decoded control for one instruction
    typedef struct packed {
        logic              regWrite;
        logic              aluSrcImm;   // Operand b from immediate
        logic              memWrite;
        logic              memToReg;    // Write back load data
        logic              branch;
        logic              branchNe;    // bne instead of beq
        logic              halt;        // ecall
        aluOpT             aluOp;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
    } ctrlT;

    // One committed instruction
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   inst;
        logic              regWe;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
    } retireT;

endpackage

`default_nettype wire

// ==== instMem.sv ====
`timescale 1ns/10ps
`default_nettype none

module instMem (
    input  wire                          CLK,
    input  wire                          loadEn,
    input  wire [cpuPkg::IMEM_AW-1:0]    loadAddr,
    input  wire [cpuPkg::XLEN-1:0]       loadData,
    input  wire [cpuPkg::IMEM_AW-1:0]    fetchAddr,
    output logic [cpuPkg::XLEN-1:0]      inst
);

    // Program store, filled from outside while the core is idle
    logic [cpuPkg::XLEN-1:0] mem [cpuPkg::IMEM_WORDS];

    always_ff @(posedge CLK) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign inst = mem[fetchAddr];   // Combinational fetch

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire                          CLK,
    input  wire                          RST,
    input  wire                          we,
    input  wire [cpuPkg::REG_AW-1:0]     waddr,
    input  wire [cpuPkg::XLEN-1:0]       wdata,
    input  wire [cpuPkg::REG_AW-1:0]     raddr1,
    input  wire [cpuPkg::REG_AW-1:0]     raddr2,
    output logic [cpuPkg::XLEN-1:0]      rdata1,
    output logic [cpuPkg::XLEN-1:0]      rdata2
);

    logic [cpuPkg::XLEN-1:0] regs [cpuPkg::REGS];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < cpuPkg::REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            // x0 never takes a write
            regs[waddr] <= wdata;
        end
    end

    // Two asynchronous read ports
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// ==== decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  wire [cpuPkg::XLEN-1:0] inst,
    output cpuPkg::ctrlT           ctrl
);

    cpuPkg::opcodeT          opcode;
    logic [2:0]              funct3;
    logic                    funct7b5;   // Selects sub and sra
    logic [cpuPkg::XLEN-1:0] immI;
    logic [cpuPkg::XLEN-1:0] immS;
    logic [cpuPkg::XLEN-1:0] immB;
    logic [cpuPkg::XLEN-1:0] immU;

    assign opcode   = cpuPkg::opcodeT'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];

    // Sign-extended immediates per format
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};

    always_comb begin
        ctrl     = '0;
        ctrl.rs1 = inst[19:15];
        ctrl.rs2 = inst[24:20];
        ctrl.rd  = inst[11:7];

        case (opcode)
            cpuPkg::OP: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'd0:    ctrl.aluOp = funct7b5 ? cpuPkg::SUB : cpuPkg::ADD;
                    3'd1:    ctrl.aluOp = cpuPkg::SLL;
                    3'd2:    ctrl.aluOp = cpuPkg::SLT;
                    3'd4:    ctrl.aluOp = cpuPkg::XOR;
                    3'd5:    ctrl.aluOp = funct7b5 ? cpuPkg::SRA : cpuPkg::SRL;
                    3'd6:    ctrl.aluOp = cpuPkg::OR;
                    3'd7:    ctrl.aluOp = cpuPkg::AND;
                    default: ctrl.regWrite = 1'b0;   // sltu runs as a no-op
                endcase
            end
            cpuPkg::OP_IMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immI;
                case (funct3)
                    3'd0:    ctrl.aluOp = cpuPkg::ADD;
                    3'd2:    ctrl.aluOp = cpuPkg::SLT;
                    3'd4:    ctrl.aluOp = cpuPkg::XOR;
                    3'd6:    ctrl.aluOp = cpuPkg::OR;
                    3'd7:    ctrl.aluOp = cpuPkg::AND;
                    default: ctrl.regWrite = 1'b0;   // Immediate shifts, sltiu
                endcase
            end
            cpuPkg::LOAD: begin
                // Word loads only
                ctrl.regWrite  = (funct3 == 3'd2);
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immI;
            end
            cpuPkg::STORE: begin
                ctrl.memWrite  = (funct3 == 3'd2);
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immS;
            end
            cpuPkg::BRANCH: begin
                ctrl.branch   = (funct3 == 3'd0) || (funct3 == 3'd1);
                ctrl.branchNe = (funct3 == 3'd1);
                ctrl.aluOp    = cpuPkg::SUB;   // Equality through zero flag
                ctrl.imm      = immB;
            end
            cpuPkg::LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = cpuPkg::PASSB;
                ctrl.imm       = immU;
            end
            cpuPkg::SYSTEM: begin
                ctrl.halt = (inst[31:7] == '0);   // ecall only
            end
            default: begin
                // Unknown opcode, nothing active
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire [cpuPkg::XLEN-1:0] a,
    input  wire [cpuPkg::XLEN-1:0] b,
    input  wire cpuPkg::aluOpT     op,
    output logic [cpuPkg::XLEN-1:0] y,
    output logic                    zero
);

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt    = b[4:0];
    assign lessThan = $signed(a) < $signed(b);   // Signed compare

    always_comb begin
        case (op)
            cpuPkg::ADD: begin
                y = a + b;
            end
            cpuPkg::SUB: begin
                y = a - b;
            end
            cpuPkg::AND: begin
                y = a & b;
            end
            cpuPkg::OR: begin
                y = a | b;
            end
            cpuPkg::XOR: begin
                y = a ^ b;
            end
            cpuPkg::SLT: begin
                y = {{(cpuPkg::XLEN-1){1'b0}}, lessThan};
            end
            cpuPkg::SLL: begin
                y = a << shamt;
            end
            cpuPkg::SRL: begin
                y = a >> shamt;
            end
            cpuPkg::SRA: begin
                y = $unsigned($signed(a) >>> shamt);   // Sign fill
            end
            cpuPkg::PASSB: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

    // Branch equality test
    assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== dataMem.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataMem (
    input  wire                      CLK,
    input  wire                      we,
    input  wire [cpuPkg::XLEN-1:0]   addr,
    input  wire [cpuPkg::XLEN-1:0]   wdata,
    output logic [cpuPkg::XLEN-1:0]  rdata
);

    logic [cpuPkg::XLEN-1:0]    mem [cpuPkg::DMEM_WORDS];
    logic [cpuPkg::DMEM_AW-1:0] wordIdx;

    // Byte offset dropped, upper bits ignored so addresses wrap
    assign wordIdx = addr[cpuPkg::DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

    assign rdata = mem[wordIdx];   // Combinational read

endmodule

`default_nettype wire

// ==== singleCpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module singleCpu (
    input  wire                          CLK,
    input  wire                          RST,
    input  wire                          run,
    input  wire                          progWe,
    input  wire [cpuPkg::IMEM_AW-1:0]    progAddr,
    input  wire [cpuPkg::XLEN-1:0]       progData,
    output logic                         retValid,
    output cpuPkg::retireT               retire,
    output logic                         halted
);

    logic [cpuPkg::XLEN-1:0] pc;
    logic [cpuPkg::XLEN-1:0] pcPlus4;
    logic [cpuPkg::XLEN-1:0] branchTarget;
    logic [cpuPkg::XLEN-1:0] nextPc;
    logic [cpuPkg::XLEN-1:0] inst;
    cpuPkg::ctrlT            ctrl;
    logic [cpuPkg::XLEN-1:0] rdata1;
    logic [cpuPkg::XLEN-1:0] rdata2;
    logic [cpuPkg::XLEN-1:0] aluB;
    logic [cpuPkg::XLEN-1:0] aluY;
    logic                    aluZero;
    logic [cpuPkg::XLEN-1:0] memRdata;
    logic [cpuPkg::XLEN-1:0] wbData;
    logic                    commit;
    logic                    branchTaken;

    // One instruction commits per cycle while running
    assign commit = run & ~halted;

    instMem u_instMem (
        .CLK       (CLK),
        .loadEn    (progWe & ~run),   // Loading only while idle
        .loadAddr  (progAddr),
        .loadData  (progData),
        .fetchAddr (pc[cpuPkg::IMEM_AW+1:2]),
        .inst      (inst)
    );

    decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    regFile u_regFile (
        .CLK    (CLK),
        .RST    (RST),
        .we     (commit & ctrl.regWrite),
        .waddr  (ctrl.rd),
        .wdata  (wbData),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign aluB = ctrl.aluSrcImm ? ctrl.imm : rdata2;

    alu u_alu (
        .a    (rdata1),
        .b    (aluB),
        .op   (ctrl.aluOp),
        .y    (aluY),
        .zero (aluZero)
    );

    dataMem u_dataMem (
        .CLK   (CLK),
        .we    (commit & ctrl.memWrite),
        .addr  (aluY),
        .wdata (rdata2),
        .rdata (memRdata)
    );

    assign wbData = ctrl.memToReg ? memRdata : aluY;

    // Next pc selection
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + ctrl.imm;
    assign branchTaken  = ctrl.branch & (ctrl.branchNe ? ~aluZero : aluZero);
    assign nextPc       = branchTaken ? branchTarget : pcPlus4;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (commit) begin
            if (ctrl.halt) begin
                halted <= 1'b1;   // pc stays on the ecall
            end else begin
                pc <= nextPc;
            end
        end
    end

    // Retire record, payload cleared when nothing is written
    assign retValid = commit;

    always_comb begin
        retire.pc    = pc;
        retire.inst  = inst;
        retire.regWe = ctrl.regWrite;
        retire.rd    = ctrl.regWrite ? ctrl.rd : '0;
        retire.wdata = ctrl.regWrite ? wbData : '0;
    end

endmodule

`default_nettype wire

// ==== cpuModel.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpuModel (
    input  wire                        CLK,
    input  wire                        RST,
    input  wire                        step,
    input  wire                        loadEn,
    input  wire [cpuPkg::IMEM_AW-1:0]  loadAddr,
    input  wire [cpuPkg::XLEN-1:0]     loadData,
    output cpuPkg::retireT             predicted,
    output logic                       wdataKnown,   // Low for loads from unwritten words
    output logic                       mHalted
);

    logic [31:0]                   prog [cpuPkg::IMEM_WORDS];
    logic [31:0]                   regs [32];
    logic [31:0]                   dmem [cpuPkg::DMEM_WORDS];
    logic [cpuPkg::DMEM_WORDS-1:0] written;
    logic [31:0]                   pc;
    logic [31:0]                   inst;
    logic [31:0]                   a;
    logic [31:0]                   b;
    logic [31:0]                   immI;
    logic [31:0]                   immS;
    logic [31:0]                   immB;
    logic [31:0]                   addr;
    logic [31:0]                   result;
    logic [31:0]                   nextPc;
    logic [cpuPkg::DMEM_AW-1:0]    word;
    logic [4:0]                    rd;
    logic                          wen;
    logic                          store;
    logic                          halt;

    // Architectural effect of the instruction at pc
    always_comb begin
        inst       = prog[pc[cpuPkg::IMEM_AW+1:2]];
        a          = regs[inst[19:15]];
        b          = regs[inst[24:20]];
        immI       = {{20{inst[31]}}, inst[31:20]};
        immS       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immB       = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        addr       = a + ((inst[6:0] == cpuPkg::STORE) ? immS : immI);
        word       = addr[cpuPkg::DMEM_AW+1:2];   // Wraps over the data words
        rd         = inst[11:7];
        result     = '0;
        wen        = 1'b0;
        store      = 1'b0;
        halt       = 1'b0;
        wdataKnown = 1'b1;
        nextPc     = pc + 4;
        case (inst[6:0])
            cpuPkg::OP: begin
                wen = 1'b1;
                case ({inst[30], inst[14:12]})
                    4'b0000: result = a + b;
                    4'b1000: result = a - b;
                    4'b0001: result = a << b[4:0];
                    4'b0010: result = {31'b0, $signed(a) < $signed(b)};
                    4'b0100: result = a ^ b;
                    4'b0101: result = a >> b[4:0];
                    4'b1101: result = $signed(a) >>> b[4:0];
                    4'b0110: result = a | b;
                    4'b0111: result = a & b;
                    default: wen = 1'b0;
                endcase
            end
            cpuPkg::OP_IMM: begin
                wen = 1'b1;
                case (inst[14:12])
                    3'd0:    result = a + immI;
                    3'd2:    result = {31'b0, $signed(a) < $signed(immI)};
                    3'd4:    result = a ^ immI;
                    3'd6:    result = a | immI;
                    3'd7:    result = a & immI;
                    default: wen = 1'b0;
                endcase
            end
            cpuPkg::LOAD: begin
                wen        = (inst[14:12] == 3'd2);
                result     = dmem[word];
                wdataKnown = written[word];
            end
            cpuPkg::STORE: store = (inst[14:12] == 3'd2);
            cpuPkg::BRANCH: begin
                if ((inst[14:12] == 3'd0 && a == b) || (inst[14:12] == 3'd1 && a != b)) begin
                    nextPc = pc + immB;
                end
            end
            cpuPkg::LUI:    begin
                wen    = 1'b1;
                result = {inst[31:12], 12'b0};
            end
            cpuPkg::SYSTEM: halt = (inst == 32'h0000_0073);
            default: begin
            end
        endcase
        predicted.pc    = pc;
        predicted.inst  = inst;
        predicted.regWe = wen;
        predicted.rd    = wen ? rd : 5'd0;
        predicted.wdata = wen ? result : '0;
    end

    always_ff @(posedge CLK) begin
        if (loadEn) begin
            prog[loadAddr] <= loadData;
        end
        if (RST) begin
            pc      <= '0;
            mHalted <= 1'b0;
            written <= '0;
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (step && !mHalted) begin
            if (wen && rd != 5'd0) begin
                regs[rd] <= result;
            end
            if (store) begin
                dmem[word]    <= b;
                written[word] <= 1'b1;
            end
            if (halt) begin
                mHalted <= 1'b1;
            end else begin
                pc <= nextPc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tbSingleCpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbSingleCpu;

    localparam int NUM_PROGS = 6;
    localparam int PROG_LEN  = 64;
    localparam int LIMIT     = NUM_PROGS * (PROG_LEN + PROG_LEN + 10 + 60);

    logic                       CLK;
    logic                       RST;
    logic                       run;
    logic                       progWe;
    logic [cpuPkg::IMEM_AW-1:0] progAddr;
    logic [cpuPkg::XLEN-1:0]    progData;
    logic                       retValid;
    logic                       halted;
    cpuPkg::retireT             retire;
    cpuPkg::retireT             predicted;
    logic                       wdataKnown;
    logic                       mHalted;
    logic [31:0]                prog [PROG_LEN];
    int                         errors;
    int                         checks;
    int                         cycles;

    singleCpu u_singleCpu (
        .CLK      (CLK),
        .RST      (RST),
        .run      (run),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .retValid (retValid),
        .retire   (retire),
        .halted   (halted)
    );

    cpuModel u_cpuModel (
        .CLK        (CLK),
        .RST        (RST),
        .step       (run),
        .loadEn     (progWe & ~run),   // Loads only count while idle
        .loadAddr   (progAddr),
        .loadData   (progData),
        .predicted  (predicted),
        .wdataKnown (wdataKnown),
        .mHalted    (mHalted)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles: the core did not halt", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERROR %0t: %s is %h, model expects %h", $time, name, got, exp);
        end
    endtask

    // Sampled mid-cycle while inputs are stable
    always @(negedge CLK) begin
        if (!RST) begin
            compareField("retValid", 32'(retValid), 32'(run & ~mHalted));
            compareField("halted", 32'(halted), 32'(mHalted));
            if (retValid) begin
                compareField("pc", retire.pc, predicted.pc);
                compareField("inst", retire.inst, predicted.inst);
                compareField("regWe", 32'(retire.regWe), 32'(predicted.regWe));
                compareField("rd", 32'(retire.rd), 32'(predicted.rd));
                if (wdataKnown) begin
                    compareField("wdata", retire.wdata, predicted.wdata);
                end
            end
        end
    end

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {off[11:5], rs2, rs1, 3'd2, off[4:0], cpuPkg::STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [2:0] f3,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpuPkg::BRANCH};
    endfunction

    function automatic logic [4:0] pickRd();
        logic [4:0] r;
        r = 5'($urandom % 16);
        return (r == 5'd1) ? 5'd0 : r;   // x1 holds the data base
    endfunction

    function automatic logic [4:0] pickSrc();
        return 5'($urandom % 20);
    endfunction

    function automatic logic [11:0] memOffset();
        return 12'(($urandom % 256) * 4);   // Reaches past the data words
    endfunction

    function automatic logic [31:0] randomOp(input logic [4:0] rd);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = 3'($urandom % 8);
        if (f3 == 3'd3) begin
            f3 = 3'd0;
        end
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
        return {f7, pickSrc(), pickSrc(), f3, rd, cpuPkg::OP};
    endfunction

    function automatic logic [31:0] randomOpImm(input logic [4:0] rd);
        logic [2:0] f3;
        f3 = 3'($urandom % 8);
        if (f3 == 3'd1 || f3 == 3'd3 || f3 == 3'd5) begin
            f3 = 3'd0;   // Shifts are not in the subset
        end
        return encI(12'($urandom), pickSrc(), f3, rd, cpuPkg::OP_IMM);
    endfunction

    task automatic genProgram();
        logic [4:0] rd;
        int         k;
        prog[0] = encI(12'(($urandom % 64) * 4), 5'd0, 3'd0, 5'd1, cpuPkg::OP_IMM);
        for (int i = 1; i < 8; i++) begin
            prog[i] = encI(12'($urandom), 5'd0, 3'd0, 5'(i + 1), cpuPkg::OP_IMM);
        end
        for (int i = 8; i < 16; i++) begin
            prog[i] = encS(memOffset(), 5'(2 + $urandom % 7), 5'd1);
        end
        for (int i = 16; i < PROG_LEN - 1; i++) begin
            rd = pickRd();
            case ($urandom % 8)
                0, 1: prog[i] = randomOp(rd);
                2:    prog[i] = randomOpImm(rd);
                3:    prog[i] = encI(memOffset(), 5'd1, 3'd2, rd, cpuPkg::LOAD);
                4:    prog[i] = encS(memOffset(), pickSrc(), 5'd1);
                5: begin
                    // Forward only and never past the ecall
                    k = 1 + int'($urandom % 8);
                    if (k > PROG_LEN - 1 - i) begin
                        k = PROG_LEN - 1 - i;
                    end
                    prog[i] = encB(13'(k * 4), 3'($urandom % 2), 5'($urandom % 4),
                                   5'($urandom % 4));
                end
                6:       prog[i] = {20'($urandom), rd, cpuPkg::LUI};
                default: prog[i] = {25'($urandom), 7'b0001111};   // Unknown opcode
            endcase
        end
        prog[PROG_LEN-1] = 32'h0000_0073;
    endtask

    task automatic runProgram();
        int pauseAt;
        genProgram();
        RST    = 1'b1;
        run    = 1'b0;
        progWe = 1'b0;
        repeat (10) @(posedge CLK);
        #1 RST = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            progWe   = 1'b1;
            progAddr = i[cpuPkg::IMEM_AW-1:0];
            progData = prog[i];
            @(posedge CLK);
            #1;
        end
        progWe  = 1'b0;
        run     = 1'b1;
        pauseAt = 16 + int'($urandom % 10);
        for (int c = 0; !halted; c++) begin
            @(posedge CLK);
            #1;
            run      = !(c >= pauseAt && c < pauseAt + 5);   // Freeze for five cycles
            progWe   = run & ($urandom % 2 == 1);          // Writes the core must ignore
            progAddr = 8'($urandom);
            progData = $urandom;
        end
        repeat (20) begin
            @(posedge CLK);
            #1;
        end
        run    = 1'b0;
        progWe = 1'b0;
    endtask

    initial begin
        CLK      = 1'b0;
        RST      = 1'b1;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        void'($urandom(93541));
        for (int p = 0; p < NUM_PROGS; p++) begin
            runProgram();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
cpuPkg.sv
instMem.sv
regFile.sv
decoder.sv
alu.sv
dataMem.sv
singleCpu.sv
cpuModel.sv
tbSingleCpu.sv

// ==== Makefile ====
TOP = tbSingleCpu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --top-module singleCpu cpuPkg.sv instMem.sv regFile.sv \
		decoder.sv alu.sv dataMem.sv singleCpu.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir
